// ==== fdsu_pkg.sv ====
// FP32 only, round to nearest even only; subnormals are not represented in any of these types
package fdsu_pkg;

  // ------------------------------------------------------------
  // widths with a meaning
  // ------------------------------------------------------------
  typedef logic [31:0]        fp32_t;    // raw single-precision value
  typedef logic [23:0]        mant_t;    // mantissa with hidden bit
  typedef logic [25:0]        root_t;    // iteration operand, room for the odd-exponent shift
  typedef logic signed [9:0]  exp_t;     // biased exponent with over/underflow margin
  typedef logic [25:0]        quot_t;    // raw quotient or root, guard bit included
  typedef logic [4:0]         status_t;  // {NV, DZ, OF, UF, NX}

  // operation select
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } fdsu_op_e;

  // ------------------------------------------------------------
  // format constants
  // ------------------------------------------------------------
  localparam int unsigned EXP_BIAS   = 127;
  localparam int unsigned ITER_STEPS = 26;            // one result bit per step
  localparam fp32_t       CANON_QNAN = 32'h7fc00000;  // sign 0, quiet bit only

endpackage

// ==== fdsu_handshake.sv ====
// one operation in flight; in_ready_o only in IDLE, result_valid_i must be a single-cycle pulse
`timescale 1ns/100ps

module fdsu_handshake (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  logic result_valid_i,
  input  logic out_ready_i,
  output logic in_ready_o,
  output logic start_o,
  output logic out_valid_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE,  // waiting for work
    BUSY,  // classify or iteration running
    DONE   // result registered, downstream stalled
  } hs_state_e;

  hs_state_e state_q, state_d;

  assign in_ready_o = (state_q == IDLE);
  assign start_o    = in_valid_i & in_ready_o;  // high in the acceptance cycle only

  // result is offered in the cycle pack raises it, then held in DONE
  // never looks at out_ready_i
  assign out_valid_o = (state_q == DONE) | ((state_q == BUSY) & result_valid_i);
  assign busy_o      = (state_q != IDLE);

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (in_valid_i) state_d = BUSY;  // operands taken this edge
      end
      BUSY: begin
        if (result_valid_i) begin
          state_d = out_ready_i ? IDLE : DONE;  // straight through or park
        end
      end
      DONE: begin
        if (out_ready_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== fdsu_classify.sv ====
// subnormal operands read as zero; operand_b_i is ignored for sqrt; start_i must be one cycle
`timescale 1ns/100ps

module fdsu_classify (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  fdsu_pkg::fdsu_op_e op_i,
  input  fdsu_pkg::fp32_t    operand_a_i,
  input  fdsu_pkg::fp32_t    operand_b_i,
  output logic               special_valid_o,
  output fdsu_pkg::fp32_t    special_result_o,
  output fdsu_pkg::status_t  special_status_o,
  output logic               norm_start_o,
  output fdsu_pkg::fdsu_op_e op_o,
  output logic               sign_o,
  output fdsu_pkg::exp_t     exp_o,
  output fdsu_pkg::root_t    mant_a_o,
  output fdsu_pkg::root_t    mant_b_o
);

  localparam fdsu_pkg::status_t ST_NV = 5'b10000;  // invalid
  localparam fdsu_pkg::status_t ST_DZ = 5'b01000;  // divide by zero

  // returns {zero, inf, qnan, snan}; all clear means normal
  function automatic logic [3:0] op_class(fdsu_pkg::fp32_t x);
    logic exp_ones;
    logic exp_zero;
    exp_ones = &x[30:23];
    exp_zero = ~|x[30:23];  // subnormals land here too
    return {exp_zero, exp_ones & ~|x[22:0], exp_ones & x[22], exp_ones & ~x[22] & |x[22:0]};
  endfunction

  fdsu_pkg::fp32_t    a_q, b_q;  // captured operands
  fdsu_pkg::fdsu_op_e op_q;
  logic               start_q;   // decode cycle marker
  logic               a_zero, a_inf, a_qnan, a_snan, a_nan;
  logic               b_zero, b_inf, b_qnan, b_snan, b_nan;
  logic               sign_div;
  logic               is_special;
  fdsu_pkg::fp32_t    spec_res;
  fdsu_pkg::status_t  spec_st;
  fdsu_pkg::mant_t    ma, mb;
  fdsu_pkg::exp_t     exp_d;
  fdsu_pkg::root_t    mant_a_d;
  logic               sign_d;

  assign {a_zero, a_inf, a_qnan, a_snan} = op_class(a_q);
  assign {b_zero, b_inf, b_qnan, b_snan} = op_class(b_q);
  assign a_nan    = a_qnan | a_snan;
  assign b_nan    = b_qnan | b_snan;
  assign sign_div = a_q[31] ^ b_q[31];
  assign ma       = {1'b1, a_q[22:0]};  // hidden bit restored
  assign mb       = {1'b1, b_q[22:0]};

  // ------------------------------------------------------------
  // special-case table
  // ------------------------------------------------------------
  always_comb begin
    is_special = 1'b1;
    spec_res   = fdsu_pkg::CANON_QNAN;  // default for every NaN outcome
    spec_st    = '0;
    if (op_q == fdsu_pkg::OP_SQRT) begin
      if (a_nan) begin
        spec_st = a_snan ? ST_NV : '0;
      end else if (a_q[31] && !a_zero) begin
        spec_st = ST_NV;  // negative, -inf included
      end else if (a_zero || a_inf) begin
        spec_res = {a_q[31], a_q[30:23], 23'b0};  // +-0 or +inf pass through
      end else begin
        is_special = 1'b0;
      end
    end else begin
      if (a_nan || b_nan) begin
        spec_st = (a_snan || b_snan) ? ST_NV : '0;
      end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
        spec_st = ST_NV;
      end else if (b_zero && !a_inf) begin
        spec_res = {sign_div, 8'hff, 23'b0};  // x/0, x finite nonzero
        spec_st  = ST_DZ;
      end else if (a_inf) begin
        spec_res = {sign_div, 8'hff, 23'b0};  // inf/finite, no flag
      end else if (a_zero || b_inf) begin
        spec_res = {sign_div, 31'b0};
      end else begin
        is_special = 1'b0;
      end
    end
  end

  // normal path: sign, unrounded exponent, iteration operand
  always_comb begin
    if (op_q == fdsu_pkg::OP_SQRT) begin
      sign_d = 1'b0;
      // floor((ea - bias) / 2) + bias == (ea + bias) >> 1
      exp_d  = fdsu_pkg::exp_t'((10'(a_q[30:23]) + 10'(fdsu_pkg::EXP_BIAS)) >> 1);
      // odd biased exponent means even unbiased one, no pre-shift
      mant_a_d = a_q[23] ? {1'b0, ma, 1'b0} : {ma, 2'b00};
    end else begin
      sign_d   = sign_div;
      exp_d    = fdsu_pkg::exp_t'(10'(a_q[30:23])) - fdsu_pkg::exp_t'(10'(b_q[30:23]))
                 + fdsu_pkg::exp_t'(fdsu_pkg::EXP_BIAS);
      mant_a_d = {2'b00, ma};
    end
  end

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_q  <= operand_a_i;
      b_q  <= operand_b_i;
      op_q <= op_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q         <= 1'b0;
      special_valid_o <= 1'b0;
      norm_start_o    <= 1'b0;
    end else begin
      start_q         <= start_i;
      special_valid_o <= start_q & is_special;   // exactly one of the two
      norm_start_o    <= start_q & ~is_special;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_q) begin
      special_result_o <= spec_res;
      special_status_o <= spec_st;
      op_o             <= op_q;
      sign_o           <= sign_d;
      exp_o            <= exp_d;
      mant_a_o         <= mant_a_d;
      mant_b_o         <= {2'b00, mb};  // divisor, unused by sqrt
    end
  end

endmodule

// ==== fdsu_iter.sv ====
// 26 restoring steps, first one in the norm_start_i cycle; op and divisor must hold until done
`timescale 1ns/100ps

module fdsu_iter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               norm_start_i,
  input  fdsu_pkg::fdsu_op_e op_i,
  input  fdsu_pkg::root_t    mant_a_i,
  input  fdsu_pkg::root_t    mant_b_i,
  output logic               iter_done_o,
  output fdsu_pkg::quot_t    quot_o,
  output logic               sticky_o
);

  localparam int unsigned REM_W = fdsu_pkg::ITER_STEPS + 2;     // sqrt trial is root plus 2 bits
  localparam int unsigned RAD_W = $bits(fdsu_pkg::root_t);
  localparam int unsigned Q_W   = $bits(fdsu_pkg::quot_t);
  localparam int unsigned CNT_W = $clog2(fdsu_pkg::ITER_STEPS);

  typedef enum logic {
    IDLE,
    RUN
  } iter_state_e;

  iter_state_e      state_q;
  logic [CNT_W-1:0] step_cnt_q;  // steps already done
  logic [REM_W-1:0] rem_q;       // partial remainder, shared by div and sqrt
  fdsu_pkg::root_t  rad_q;       // radicand bits still to bring down
  fdsu_pkg::quot_t  quot_q;      // quotient, or partial root for sqrt

  logic [REM_W-1:0] rem_cur;
  logic [REM_W-1:0] part;
  logic [REM_W-1:0] trial;
  logic [REM_W-1:0] diff;
  logic [REM_W-1:0] rem_nxt;
  fdsu_pkg::root_t  rad_cur;
  fdsu_pkg::quot_t  quot_cur;
  logic             step_en;
  logic             take;
  logic             last_step;

  assign step_en   = norm_start_i | (state_q == RUN);
  assign last_step = (state_q == RUN) && (step_cnt_q == CNT_W'(fdsu_pkg::ITER_STEPS - 1));

  // ------------------------------------------------------------
  // one step: start values come straight from the inputs
  // ------------------------------------------------------------
  always_comb begin
    if (norm_start_i) begin
      rem_cur  = (op_i == fdsu_pkg::OP_DIV) ? REM_W'(mant_a_i) : '0;  // dividend or empty
      rad_cur  = mant_a_i;
      quot_cur = '0;
    end else begin
      rem_cur  = rem_q;
      rad_cur  = rad_q;
      quot_cur = quot_q;
    end

    if (op_i == fdsu_pkg::OP_SQRT) begin
      // bring down the next radicand pair; rem < 2^26 here so top bits are zero
      part  = {rem_cur[REM_W-3:0], rad_cur[RAD_W-1 -: 2]};
      trial = {quot_cur, 2'b01};  // 4r + 1
    end else begin
      part  = rem_cur;
      trial = REM_W'(mant_b_i);   // divisor
    end

    take = (part >= trial);                 // result bit
    diff = take ? part - trial : part;      // restore by not subtracting
    rem_nxt = (op_i == fdsu_pkg::OP_SQRT) ? diff : {diff[REM_W-2:0], 1'b0};
  end

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      step_cnt_q  <= '0;
      iter_done_o <= 1'b0;
    end else begin
      iter_done_o <= last_step;  // raised with the final bit in place
      if (norm_start_i) begin
        state_q    <= RUN;
        step_cnt_q <= CNT_W'(1);  // first step taken on this edge
      end else if (last_step) begin
        state_q <= IDLE;
      end else if (state_q == RUN) begin
        step_cnt_q <= step_cnt_q + 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rem_q  <= rem_nxt;
      rad_q  <= {rad_cur[RAD_W-3:0], 2'b00};
      quot_q <= {quot_cur[Q_W-2:0], take};
    end
    if (last_step) begin
      sticky_o <= |diff;  // anything left over below the guard bit
    end
  end

  assign quot_o = quot_q;

endmodule

// ==== fdsu_pack.sv ====
// RNE only; results below the normal range flush to signed zero, result_o holds until next pulse
`timescale 1ns/100ps

module fdsu_pack (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              special_valid_i,
  input  fdsu_pkg::fp32_t   special_result_i,
  input  fdsu_pkg::status_t special_status_i,
  input  logic              iter_done_i,
  input  fdsu_pkg::quot_t   quot_i,
  input  logic              sticky_i,
  input  logic              sign_i,
  input  fdsu_pkg::exp_t    exp_i,
  output logic              result_valid_o,
  output fdsu_pkg::fp32_t   result_o,
  output fdsu_pkg::status_t status_o
);

  localparam fdsu_pkg::exp_t    EXP_INF = fdsu_pkg::exp_t'(2 * fdsu_pkg::EXP_BIAS + 1);
  localparam fdsu_pkg::status_t ST_OF   = 5'b00100;
  localparam fdsu_pkg::status_t ST_UF   = 5'b00010;
  localparam fdsu_pkg::status_t ST_NX   = 5'b00001;

  fdsu_pkg::mant_t   mant;        // 1.f before rounding
  logic              guard;
  logic              sticky_all;
  logic              round_up;
  logic              inexact;
  logic [24:0]       mant_rnd;    // bit 24 is the rounding carry
  fdsu_pkg::exp_t    exp_norm;
  fdsu_pkg::exp_t    exp_rnd;
  fdsu_pkg::fp32_t   norm_result;
  fdsu_pkg::status_t norm_status;

  // ------------------------------------------------------------
  // normalize, round, range check
  // ------------------------------------------------------------
  always_comb begin
    if (quot_i[25]) begin
      mant       = quot_i[25:2];
      guard      = quot_i[1];
      sticky_all = quot_i[0] | sticky_i;
      exp_norm   = exp_i;
    end else begin
      // quotient below 1, one place left; sqrt never lands here
      mant       = quot_i[24:1];
      guard      = quot_i[0];
      sticky_all = sticky_i;
      exp_norm   = exp_i - fdsu_pkg::exp_t'(1);
    end

    round_up = guard & (sticky_all | mant[0]);  // ties to even
    inexact  = guard | sticky_all;
    mant_rnd = {1'b0, mant} + 25'(round_up);
    exp_rnd  = exp_norm + fdsu_pkg::exp_t'(mant_rnd[24]);

    if (exp_rnd >= EXP_INF) begin
      norm_result = {sign_i, 8'hff, 23'b0};
      norm_status = ST_OF | ST_NX;
    end else if (exp_rnd <= fdsu_pkg::exp_t'(0)) begin
      norm_result = {sign_i, 31'b0};  // flush to zero
      norm_status = ST_UF | ST_NX;
    end else begin
      // on carry the fraction bits are already zero
      norm_result = {sign_i, exp_rnd[7:0], mant_rnd[22:0]};
      norm_status = inexact ? ST_NX : '0;
    end
  end

  // ------------------------------------------------------------
  // result register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= special_valid_i | iter_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (special_valid_i) begin
      result_o <= special_result_i;
      status_o <= special_status_i;
    end else if (iter_done_i) begin
      result_o <= norm_result;
      status_o <= norm_status;
    end
  end

endmodule

// ==== fdsu_top.sv ====
// FP32 div/sqrt, RNE, no subnormals; one operation at a time, new input only after result transfer
`timescale 1ns/100ps

module fdsu_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  fdsu_pkg::fdsu_op_e op_i,
  input  fdsu_pkg::fp32_t    operand_a_i,
  input  fdsu_pkg::fp32_t    operand_b_i,  // ignored for sqrt
  input  logic               out_ready_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output fdsu_pkg::fp32_t    result_o,
  output fdsu_pkg::status_t  status_o,
  output logic               busy_o
);

  logic               start;           // acceptance pulse
  logic               special_valid;
  fdsu_pkg::fp32_t    special_result;
  fdsu_pkg::status_t  special_status;
  logic               norm_start;
  fdsu_pkg::fdsu_op_e iter_op;
  logic               norm_sign;
  fdsu_pkg::exp_t     norm_exp;
  fdsu_pkg::root_t    mant_a;
  fdsu_pkg::root_t    mant_b;
  logic               iter_done;
  fdsu_pkg::quot_t    quot;
  logic               sticky;
  logic               result_valid;

  fdsu_handshake handshake_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .result_valid_i (result_valid),
    .out_ready_i    (out_ready_i),
    .in_ready_o     (in_ready_o),
    .start_o        (start),
    .out_valid_o    (out_valid_o),
    .busy_o         (busy_o)
  );

  fdsu_classify classify_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .start_i          (start),
    .op_i             (op_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .special_valid_o  (special_valid),
    .special_result_o (special_result),
    .special_status_o (special_status),
    .norm_start_o     (norm_start),
    .op_o             (iter_op),
    .sign_o           (norm_sign),
    .exp_o            (norm_exp),
    .mant_a_o         (mant_a),
    .mant_b_o         (mant_b)
  );

  fdsu_iter iter_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .norm_start_i (norm_start),
    .op_i         (iter_op),
    .mant_a_i     (mant_a),
    .mant_b_i     (mant_b),
    .iter_done_o  (iter_done),
    .quot_o       (quot),
    .sticky_o     (sticky)
  );

  fdsu_pack pack_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .special_valid_i  (special_valid),
    .special_result_i (special_result),
    .special_status_i (special_status),
    .iter_done_i      (iter_done),
    .quot_i           (quot),
    .sticky_i         (sticky),
    .sign_i           (norm_sign),
    .exp_i            (norm_exp),
    .result_valid_o   (result_valid),
    .result_o         (result_o),
    .status_o         (status_o)
  );

endmodule

// ==== tb_fdsu_sva.sv ====
// handshake checks bound into fdsu_top; all checks are off while rst_n_i is low
`timescale 1ns/100ps

module tb_fdsu_sva (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              in_valid_i,
  input logic              in_ready_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input fdsu_pkg::fp32_t   result_i,
  input fdsu_pkg::status_t status_i,
  input logic              busy_i
);

  // ------------------------------------------------------------
  // handshake rules
  // ------------------------------------------------------------
  a_no_accept_while_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(in_ready_i && out_valid_i))
    else $error("input ready while a result is offered");

  // stalled output must not move
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i) && $stable(status_i))
    else $error("output changed under back-pressure");

  a_busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> busy_i)
    else $error("out_valid_o high while not busy");

  a_accept_drops_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && in_ready_i |=> !in_ready_i && busy_i)  // one operation in flight
    else $error("still ready after accepting an operation");

endmodule

bind fdsu_top tb_fdsu_sva sva_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_valid_i  (in_valid_i),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .status_i    (status_o),
  .busy_i      (busy_o)
);

// ==== tb_fdsu.sv ====
// reads fdsu_input.txt from the run directory; one operation at a time, out_ready_i is random
`timescale 1ns/100ps

module tb_fdsu;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 3;
  localparam int CYC_PER_OP = 64;   // 28 compute cycles plus handshake and stall margin

  logic               clk_i;
  logic               rst_n_i;
  logic               in_valid_i;
  fdsu_pkg::fdsu_op_e op_i;
  fdsu_pkg::fp32_t    operand_a_i;
  fdsu_pkg::fp32_t    operand_b_i;
  logic               out_ready_i;
  logic               in_ready_o;
  logic               out_valid_o;
  fdsu_pkg::fp32_t    result_o;
  fdsu_pkg::status_t  status_o;
  logic               busy_o;

  logic [31:0]        vec_op[$];    // 0 div, 1 sqrt
  fdsu_pkg::fp32_t    vec_a[$];
  fdsu_pkg::fp32_t    vec_b[$];
  fdsu_pkg::fp32_t    vec_res[$];   // expected result
  fdsu_pkg::status_t  vec_st[$];    // expected flags
  int                 cycle_cnt;
  int                 cycle_limit;  // set from the vector count before the first edge
  logic [15:0]        lfsr_q;

  fdsu_top fdsu_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, shifting toward the lsb
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    logic fb;
    fb = s[0] ^ s[2] ^ s[3] ^ s[5];
    return {fb, s[15:1]};
  endfunction

  // ------------------------------------------------------------
  // back-pressure and watchdog
  // ------------------------------------------------------------
  always @(posedge clk_i) begin : ready_gen
    logic [15:0] nxt;
    nxt = lfsr_step(lfsr_q);  // one step per bit taken
    lfsr_q      <= nxt;
    out_ready_i <= nxt[15];
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_result(string name, fdsu_pkg::fp32_t exp_val, fdsu_pkg::fp32_t act_val);
    if (act_val !== exp_val) begin
      $display("** Error: %s result expected %h actual %h", name, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_status(string name, fdsu_pkg::status_t exp_val,
                              fdsu_pkg::status_t act_val);
    if (act_val !== exp_val) begin
      $display("** Error: %s status expected %b actual %b", name, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "status mismatch");
    end
  endtask

  // comment lines do not scan as five hex fields and are skipped
  task automatic load_vectors();
    int          fd;
    string       line;
    logic [31:0] f_op, f_a, f_b, f_res, f_st;
    fd = $fopen("fdsu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open fdsu_input.txt for reading");
      $display("Simulation failed");
      $fatal(1, "stimulus file missing");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0 &&
            $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_st) == 5) begin
          vec_op.push_back(f_op);
          vec_a.push_back(f_a);
          vec_b.push_back(f_b);
          vec_res.push_back(f_res);
          vec_st.push_back(fdsu_pkg::status_t'(f_st));
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // one operation, in to out
  // ------------------------------------------------------------
  task automatic run_vector(int idx);
    string name;
    name = $sformatf("vector %0d %s", idx, vec_op[idx][0] ? "sqrt" : "div");
    @(posedge clk_i);
    in_valid_i  <= 1'b1;
    op_i        <= fdsu_pkg::fdsu_op_e'(vec_op[idx][0]);
    operand_a_i <= vec_a[idx];
    operand_b_i <= vec_b[idx];
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);  // valid held until taken
    @(posedge clk_i);                      // acceptance edge
    in_valid_i <= 1'b0;
    @(negedge clk_i);
    while (!(out_valid_o && out_ready_i)) @(negedge clk_i);
    check_result(name, vec_res[idx], result_o);  // stable before the transfer edge
    check_status(name, vec_st[idx], status_o);
    @(posedge clk_i);                      // output transfer
  endtask

  initial begin
    in_valid_i  = 1'b0;
    op_i        = fdsu_pkg::OP_DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    out_ready_i = 1'b0;
    rst_n_i     = 1'b0;
    lfsr_q      = 16'd94;  // seed
    cycle_cnt   = 0;
    cycle_limit = 0;
    load_vectors();
    if (vec_a.size() == 0) begin
      $display("fdsu_input.txt holds no operations");
      $display("Simulation failed");
      $fatal(1, "empty stimulus");
    end
    cycle_limit = vec_a.size() * CYC_PER_OP + 100;

    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    if (!in_ready_o || out_valid_o || busy_o) begin
      $display("handshake outputs wrong after reset");
      $display("Simulation failed");
      $fatal(1, "bad reset state");
    end

    for (int i = 0; i < vec_a.size(); i++) begin
      run_vector(i);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== fdsu_input.txt ====
// op (0 div, 1 sqrt)  operand_a  operand_b  expected_result  expected_status
// status bits are {NV, DZ, OF, UF, NX}; all columns hex, operand_b ignored for sqrt
0 40c00000 40000000 40400000 00
0 3f800000 3f000000 40000000 00
0 3f800000 40400000 3eaaaaab 01
0 40000000 40400000 3f2aaaab 01
1 40800000 deadbeef 40000000 00
1 40000000 00000000 3fb504f3 01
1 3e800000 00000000 3f000000 00
0 3f800000 00000000 7f800000 08
0 00000000 00000000 7fc00000 10
1 bf800000 00000000 7fc00000 10
0 7f800001 3f800000 7fc00000 10
0 c0400000 7f800000 80000000 00
0 7f000000 00800000 7f800000 05
0 00800000 7f000000 00000000 03
0 c0e00000 40000000 c0600000 00
1 41100000 00000000 40400000 00
0 ff800000 40000000 ff800000 00
1 80000000 00000000 80000000 00
1 7fc00000 00000000 7fc00000 00
1 00000001 00000000 00000000 00

// ==== vlog.f ====
fdsu_pkg.sv
fdsu_handshake.sv
fdsu_classify.sv
fdsu_iter.sv
fdsu_pack.sv
fdsu_top.sv
tb_fdsu_sva.sv
tb_fdsu.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the FP32 div/sqrt testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_fdsu -o sim_fdsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_fdsu 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^Simulation completed successfully$'; then
  exit 0
fi

echo "pass message not found in simulator output"
exit 1
